//--- src/dbg_pkg.sv
package dbg_pkg;

    localparam int DATA_W        = 32;
    localparam int MODE_W        = 8;
    localparam int NUM_FIELDS    = 9;
    localparam int MAX_LABEL_LEN = 4;

    localparam logic [MODE_W-1:0] PRINT_MODE_CODE = 8'h50; // 'P' on the console

    localparam logic [7:0] ASCII_EQ = 8'h3D;
    localparam logic [7:0] ASCII_CR = 8'h0D;
    localparam logic [7:0] ASCII_LF = 8'h0A;

    typedef logic [3:0] field_idx_t;
    typedef logic [1:0] char_idx_t;

    // Byte 0 holds the first character, unused bytes are zero
    typedef logic [0:MAX_LABEL_LEN-1][7:0] label_t;

    localparam label_t LABEL_CHARS [NUM_FIELDS] = '{
        {"NPC", ASCII_EQ},
        {"PC", ASCII_EQ, 8'h00},
        {"IR", ASCII_EQ, 8'h00},
        {"CTL", ASCII_EQ},
        {"A", ASCII_EQ, 16'h0000},
        {"B", ASCII_EQ, 16'h0000},
        {"IMM", ASCII_EQ},
        {"Y", ASCII_EQ, 16'h0000},
        {"MDR", ASCII_EQ}
    };

    // Label length with the '=' counted
    localparam logic [2:0] LABEL_LEN [NUM_FIELDS] = '{
        3'd4, 3'd3, 3'd3, 3'd4, 3'd2, 3'd2, 3'd4, 3'd2, 3'd4
    };

    // Field order matches the print order
    typedef struct packed {
        logic [DATA_W-1:0] npc;
        logic [DATA_W-1:0] pc;
        logic [DATA_W-1:0] ir;
        logic [DATA_W-1:0] ctl;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] imm;
        logic [DATA_W-1:0] y;
        logic [DATA_W-1:0] mdr;
    } datapath_regs_t;

    typedef struct packed {
        logic              is_data;  // 0 char, 1 data word
        logic [DATA_W-1:0] payload;  // Chars zero-extended
    } tx_item_t;

endpackage

//--- src/dbg_snapshot.sv
`timescale 1ns/1ns

module dbg_snapshot
    import dbg_pkg::*;
(
    input  logic              clk,
    input  logic              rstn,
    input  logic [MODE_W-1:0] sel_mode,
    input  datapath_regs_t    regs,
    output logic              start,
    output logic              active,
    output datapath_regs_t    snap
);

    logic mode_hit;
    logic entry;

    assign mode_hit = (sel_mode == PRINT_MODE_CODE);
    assign entry    = mode_hit && !active; // Rising edge of the match

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            active <= 1'b0;
            start  <= 1'b0;
        end else begin
            active <= mode_hit;
            start  <= entry;
        end
    end

    // Frozen for the whole print so all nine values belong to one cycle
    always_ff @(posedge clk) begin
        if (entry) begin
            snap <= regs;
        end
    end

endmodule

//--- src/dbg_field_seq.sv
`timescale 1ns/1ns

module dbg_field_seq
    import dbg_pkg::*;
(
    input  logic           clk,
    input  logic           rstn,
    input  logic           start,
    input  logic           active,
    input  datapath_regs_t snap,
    input  logic           item_taken,
    output logic           item_valid,
    output tx_item_t       item,
    output logic           finish
);

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_LABEL,
        PH_DATA,
        PH_EOL,
        PH_DONE
    } phase_t;

    phase_t            phase;
    field_idx_t        field_idx;
    char_idx_t         char_idx;
    char_idx_t         label_last;
    logic              field_last;
    logic [7:0]        label_char;
    logic [DATA_W-1:0] field_word;

    assign label_last = char_idx_t'(LABEL_LEN[field_idx] - 3'd1);
    assign field_last = (field_idx == field_idx_t'(NUM_FIELDS - 1));
    assign label_char = LABEL_CHARS[field_idx][char_idx];

    always_comb begin
        case (field_idx)
            4'd0:    field_word = snap.npc;
            4'd1:    field_word = snap.pc;
            4'd2:    field_word = snap.ir;
            4'd3:    field_word = snap.ctl;
            4'd4:    field_word = snap.a;
            4'd5:    field_word = snap.b;
            4'd6:    field_word = snap.imm;
            4'd7:    field_word = snap.y;
            default: field_word = snap.mdr;
        endcase
    end

    assign item_valid = (phase == PH_LABEL) || (phase == PH_DATA) || (phase == PH_EOL);

    always_comb begin
        item.is_data = 1'b0;
        item.payload = '0;
        case (phase)
            PH_LABEL: begin
                item.payload = DATA_W'(label_char);
            end
            PH_DATA: begin
                item.is_data = 1'b1;
                item.payload = field_word;
            end
            PH_EOL: begin
                item.payload = (char_idx == 2'd0) ? DATA_W'(ASCII_CR) : DATA_W'(ASCII_LF);
            end
            default: begin
                item.payload = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase     <= PH_IDLE;
            field_idx <= '0;
            char_idx  <= '0;
            finish    <= 1'b0;
        end else if (!active) begin // Mode left, abort or clear finish
            phase     <= PH_IDLE;
            field_idx <= '0;
            char_idx  <= '0;
            finish    <= 1'b0;
        end else begin
            case (phase)
                PH_IDLE: begin
                    if (start) begin
                        phase     <= PH_LABEL;
                        field_idx <= '0;
                        char_idx  <= '0;
                    end
                end
                PH_LABEL: begin
                    if (item_taken) begin
                        if (char_idx == label_last) begin
                            phase    <= PH_DATA;
                            char_idx <= '0;
                        end else begin
                            char_idx <= char_idx + 2'd1;
                        end
                    end
                end
                PH_DATA: begin
                    if (item_taken) begin
                        if (field_last) begin
                            phase <= PH_EOL; // CR then LF
                        end else begin
                            phase     <= PH_LABEL;
                            field_idx <= field_idx + 4'd1;
                        end
                        char_idx <= '0;
                    end
                end
                PH_EOL: begin
                    if (item_taken) begin
                        if (char_idx == 2'd1) begin
                            phase  <= PH_DONE;
                            finish <= 1'b1;
                        end else begin
                            char_idx <= char_idx + 2'd1;
                        end
                    end
                end
                default: begin
                    phase <= PH_DONE; // Wait here until the mode is left
                end
            endcase
        end
    end

endmodule

//--- src/dbg_tx_req.sv
`timescale 1ns/1ns

module dbg_tx_req
    import dbg_pkg::*;
(
    input  logic              clk,
    input  logic              rstn,
    input  logic              active,
    input  logic              item_valid,
    input  tx_item_t          item,
    input  logic              ack_tx,
    output logic              item_taken,
    output logic              req_tx,
    output logic              type_tx,
    output logic [DATA_W-1:0] dout
);

    logic load;

    // Only from idle, which also gives the low cycle after each transfer
    assign load       = active && item_valid && !req_tx;
    assign item_taken = req_tx && ack_tx;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            req_tx <= 1'b0;
        end else if (!active) begin
            req_tx <= 1'b0; // Abort drops the request
        end else if (req_tx) begin
            if (ack_tx) begin
                req_tx <= 1'b0;
            end
        end else if (load) begin
            req_tx <= 1'b1;
        end
    end

    // Held stable while the request waits for ack
    always_ff @(posedge clk) begin
        if (load) begin
            type_tx <= item.is_data;
            dout    <= item.payload;
        end
    end

endmodule

//--- src/dbg_print.sv
`timescale 1ns/1ns

module dbg_print
    import dbg_pkg::*;
(
    input  logic              clk,
    input  logic              rstn,
    input  logic [MODE_W-1:0] sel_mode,
    input  datapath_regs_t    regs,
    input  logic              ack_tx,
    output logic              req_tx,
    output logic              type_tx,
    output logic [DATA_W-1:0] dout,
    output logic              finish
);

    logic           start;
    logic           active;
    datapath_regs_t snap;
    logic           item_valid;
    tx_item_t       item;
    logic           item_taken;

    dbg_snapshot i_snapshot (
        .clk      (clk),
        .rstn     (rstn),
        .sel_mode (sel_mode),
        .regs     (regs),
        .start    (start),
        .active   (active),
        .snap     (snap)
    );

    dbg_field_seq i_field_seq (
        .clk        (clk),
        .rstn       (rstn),
        .start      (start),
        .active     (active),
        .snap       (snap),
        .item_taken (item_taken),
        .item_valid (item_valid),
        .item       (item),
        .finish     (finish)
    );

    dbg_tx_req i_tx_req (
        .clk        (clk),
        .rstn       (rstn),
        .active     (active),
        .item_valid (item_valid),
        .item       (item),
        .ack_tx     (ack_tx),
        .item_taken (item_taken),
        .req_tx     (req_tx),
        .type_tx    (type_tx),
        .dout       (dout)
    );

endmodule

//--- dv/dbg_print_chk.sv
`timescale 1ns/1ns

module dbg_print_chk
    import dbg_pkg::*;
(
    input logic              clk,
    input logic              rstn,
    input logic              active,
    input logic              ack_tx,
    input logic              req_tx,
    input logic              type_tx,
    input logic [DATA_W-1:0] dout,
    input logic              finish
);

    int err_cnt = 0;

    // Request and payload wait for ack unless the mode was left
    hold_until_ack: assert property (@(posedge clk) disable iff (!rstn)
        req_tx && !ack_tx && active |=> req_tx && $stable(type_tx) && $stable(dout))
    else begin
        $error("req_tx, type_tx or dout changed before ack_tx");
        err_cnt++;
    end

    gap_after_transfer: assert property (@(posedge clk) disable iff (!rstn)
        req_tx && ack_tx |=> !req_tx)
    else begin
        $error("req_tx stayed high in the cycle after a transfer");
        err_cnt++;
    end

    quiet_in_reset: assert property (@(posedge clk)
        !rstn |=> !req_tx && !finish)
    else begin
        $error("req_tx or finish high during reset");
        err_cnt++;
    end

    quiet_after_reset: assert property (@(posedge clk)
        $rose(rstn) |=> !req_tx && !finish)
    else begin
        $error("req_tx or finish high in the first cycle after reset");
        err_cnt++;
    end

    no_req_when_done: assert property (@(posedge clk) disable iff (!rstn)
        finish |-> !req_tx)
    else begin
        $error("req_tx high while finish is high");
        err_cnt++;
    end

endmodule

bind dbg_print dbg_print_chk i_chk (.*);

//--- dv/dbg_print_tb.sv
`timescale 1ns/1ns

module dbg_print_tb
    import dbg_pkg::*;
;

    localparam int              WAIT_LIMIT  = 2000; // Cycles per wait loop
    localparam int              PRINT_ITEMS = 39;
    localparam logic [MODE_W-1:0] IDLE_MODE  = 8'h00;
    localparam logic [MODE_W-1:0] OTHER_MODE = 8'h41;

    logic              clk      = 1'b0;
    logic              rstn     = 1'b0;
    logic [MODE_W-1:0] sel_mode = '0;
    datapath_regs_t    regs     = '0;
    logic              ack_tx   = 1'b0;
    logic              req_tx;
    logic              type_tx;
    logic [DATA_W-1:0] dout;
    logic              finish;

    logic [31:0]    data_seed = 32'h40996568;
    logic [31:0]    ack_seed  = ~32'h40996568;
    bit             bp_on     = 1'b0; // Random ack delays
    bit             armed     = 1'b0;
    int             ack_wait  = 0;
    tx_item_t       rx_q[$];
    tx_item_t       exp_q[$];
    datapath_regs_t entry_regs;
    string          test_name;
    int             test_errs;
    int             tests_run    = 0;
    int             tests_failed = 0;

    dbg_print i_dut (
        .clk      (clk),
        .rstn     (rstn),
        .sel_mode (sel_mode),
        .regs     (regs),
        .ack_tx   (ack_tx),
        .req_tx   (req_tx),
        .type_tx  (type_tx),
        .dout     (dout),
        .finish   (finish)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic datapath_regs_t rand_regs();
        datapath_regs_t r;
        for (int f = 0; f < NUM_FIELDS; f++) begin
            data_seed = xorshift(data_seed);
            r[DATA_W*f +: DATA_W] = data_seed;
        end
        return r;
    endfunction

    // Transmitter side, one recorded item per req/ack transfer
    always @(posedge clk) begin
        if (!rstn) begin
            ack_tx <= 1'b0;
            armed  = 1'b0;
        end else if (req_tx && ack_tx) begin
            rx_q.push_back(tx_item_t'({type_tx, dout}));
            ack_tx <= 1'b0;
            armed  = 1'b0;
        end else if (req_tx) begin
            if (!armed) begin
                ack_seed = xorshift(ack_seed);
                ack_wait = bp_on ? int'(ack_seed % 6) : 0;
                armed    = 1'b1;
            end
            if (ack_wait == 0) begin
                ack_tx <= 1'b1;
            end else begin
                ack_wait--;
            end
        end else begin
            ack_tx <= 1'b0;
            armed  = 1'b0;
        end
    end

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errs == 0) begin
            $display("Test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", test_name, test_errs);
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR in %s: %s", test_name, msg);
        test_errs++;
    endtask

    task automatic check_value(input string what, input logic [32:0] exp,
                               input logic [32:0] act);
        assert (act === exp) else begin
            $display("FAIL %s %s: expected %0h, actual %0h", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    // Labels from the package tables, words in NPC..MDR order, then CR LF
    task automatic build_expected(input datapath_regs_t r);
        exp_q.delete();
        for (int f = 0; f < NUM_FIELDS; f++) begin
            for (int c = 0; c < LABEL_LEN[f]; c++) begin
                exp_q.push_back({1'b0, 24'h0, LABEL_CHARS[f][c]});
            end
            exp_q.push_back({1'b1, r[DATA_W*(NUM_FIELDS-1-f) +: DATA_W]});
        end
        exp_q.push_back({1'b0, 24'h0, 8'h0D});
        exp_q.push_back({1'b0, 24'h0, 8'h0A});
    endtask

    task automatic check_stream();
        int n;
        build_expected(entry_regs);
        check_value("item count", exp_q.size(), rx_q.size());
        n = (rx_q.size() < exp_q.size()) ? rx_q.size() : exp_q.size();
        for (int i = 0; i < n; i++) begin
            check_value($sformatf("item %0d", i), exp_q[i], rx_q[i]);
        end
    endtask

    task automatic start_print(input datapath_regs_t r);
        @(negedge clk);
        rx_q.delete();
        @(posedge clk);
        regs       <= r;
        sel_mode   <= PRINT_MODE_CODE;
        entry_regs = r;
    endtask

    task automatic leave_mode(input logic [MODE_W-1:0] mode);
        @(posedge clk);
        sel_mode <= mode;
    endtask

    // Optionally scrambles the register inputs every cycle while waiting
    task automatic wait_finish(input logic level, input bit scramble);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            if (scramble) begin
                regs <= rand_regs();
            end
            @(negedge clk);
            n++;
        end while (finish !== level && n < WAIT_LIMIT);
        if (finish !== level) begin
            report_error($sformatf("finish did not reach %0b within %0d cycles",
                                   level, WAIT_LIMIT));
        end
    endtask

    task automatic wait_rx_count(input int count);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (rx_q.size() < count && n < WAIT_LIMIT);
        if (rx_q.size() < count) begin
            report_error($sformatf("fewer than %0d items arrived in time", count));
        end
    endtask

    task automatic wait_req_low();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (req_tx !== 1'b0 && n < WAIT_LIMIT);
        if (req_tx !== 1'b0) begin
            report_error("req_tx did not fall after the mode was left");
        end
    endtask

    task automatic hold_check(input int cycles, input logic exp_req, input logic exp_fin);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_value("req_tx", exp_req, req_tx);
            check_value("finish", exp_fin, finish);
        end
    endtask

    initial begin
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        repeat (2) @(posedge clk);

        begin_test("full_print");
        start_print(rand_regs());
        wait_finish(1'b1, 1'b0);
        check_value("items at finish", PRINT_ITEMS, rx_q.size());
        check_stream();
        leave_mode(IDLE_MODE);
        wait_finish(1'b0, 1'b0);
        end_test();

        begin_test("snapshot");
        start_print(rand_regs());
        wait_finish(1'b1, 1'b1);
        check_stream();
        leave_mode(IDLE_MODE);
        wait_finish(1'b0, 1'b0);
        end_test();

        begin_test("back_pressure");
        bp_on = 1'b1;
        start_print(rand_regs());
        wait_finish(1'b1, 1'b0);
        check_stream();
        leave_mode(IDLE_MODE);
        wait_finish(1'b0, 1'b0);
        bp_on = 1'b0;
        end_test();

        begin_test("abort");
        start_print(rand_regs());
        wait_rx_count(10);
        leave_mode(IDLE_MODE);
        wait_req_low();
        hold_check(8, 1'b0, 1'b0);
        start_print(rand_regs());
        wait_rx_count(1);
        if (rx_q.size() > 0) begin
            check_value("first item after restart", {1'b0, 24'h0, 8'h4E}, rx_q[0]);
        end
        wait_finish(1'b1, 1'b0);
        check_stream();
        leave_mode(IDLE_MODE);
        wait_finish(1'b0, 1'b0);
        end_test();

        begin_test("one_per_entry");
        start_print(rand_regs());
        wait_finish(1'b1, 1'b0);
        check_stream();
        hold_check(20, 1'b0, 1'b1); // Mode still held
        leave_mode(OTHER_MODE);
        wait_finish(1'b0, 1'b0);
        hold_check(20, 1'b0, 1'b0);
        check_value("items after other mode", PRINT_ITEMS, rx_q.size());
        leave_mode(IDLE_MODE);
        end_test();

        repeat (2) @(posedge clk);
        $display("Tests run: %0d, failed: %0d, assertion failures: %0d",
                 tests_run, tests_failed, i_dut.i_chk.err_cnt);
        if (tests_failed == 0 && i_dut.i_chk.err_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
src/dbg_pkg.sv
src/dbg_snapshot.sv
src/dbg_field_seq.sv
src/dbg_tx_req.sv
src/dbg_print.sv
dv/dbg_print_chk.sv
dv/dbg_print_tb.sv
